//--- design/bfs_settings.svh
//********************************************************************
// Build-time sizes and field widths for the BFS frontier engine
//********************************************************************

`ifndef BFS_SETTINGS_SVH
`define BFS_SETTINGS_SVH

// Queue rows, also the largest legal vertex count
`define BFS_Q_SIZE 64

// Neighbor lanes working in parallel
`define BFS_LANES 4

// Field widths of a frontier entry, 32 bits together
`define BFS_VERTEX_W 24
`define BFS_LEVEL_W 8

`endif

//--- design/bfs_pkg.sv
//********************************************************************
// Shared types: frontier entries, lane jobs, lane results, visits
//********************************************************************

`default_nettype none

`include "bfs_settings.svh"

package bfs_pkg;

  // One queue word, level in the top byte
  typedef struct packed {
    logic [`BFS_LEVEL_W-1:0]  level;
    logic [`BFS_VERTEX_W-1:0] vertex;
  } frontier_entry_t;

  // Dispatcher to lane
  typedef struct packed {
    frontier_entry_t entry;
  } lane_job_t;

  // Lane to collector, child[1] is 2v+1 and is flagged by valid[1]
  typedef struct packed {
    logic [1:0]            valid;
    frontier_entry_t [1:0] child;
  } lane_result_t;

  // One visited vertex on the output stream
  typedef struct packed {
    frontier_entry_t entry;
  } visit_t;

endpackage

`default_nettype wire

//--- design/queue_main.sv
//********************************************************************
// Frontier queue: two slots per row, dual enqueue, single dequeue
//********************************************************************

`default_nettype none

module queue_main #(
  parameter int Q_SIZE = 64
) (
  input  logic                           clk,
  input  logic                           bfs_rst,
  input  logic [1:0]                     enqueue_req,
  input  bfs_pkg::frontier_entry_t [1:0] wdata_in,
  input  logic                           dequeue_req,
  output bfs_pkg::frontier_entry_t       rdata_out,
  output logic                           queue_full,
  output logic                           queue_empty
);

  // Q_SIZE must be a power of two so the pointers wrap cleanly
  localparam int PW = $clog2(Q_SIZE);

  bfs_pkg::frontier_entry_t slot_hi [Q_SIZE];
  bfs_pkg::frontier_entry_t slot_lo [Q_SIZE];
  logic [Q_SIZE-1:0]        vld_hi;
  logic [Q_SIZE-1:0]        vld_lo;

  // Row pointers with a polarity bit on top
  logic [PW:0]   head;
  logic [PW:0]   tail;
  logic [PW-1:0] head_row;
  logic [PW-1:0] tail_row;
  logic          do_enq;
  logic          do_deq;
  logic          head_last;

  assign head_row = head[PW-1:0];
  assign tail_row = tail[PW-1:0];

  // A row with no valid slot is never written
  assign do_enq = (|enqueue_req) && !queue_full;
  assign do_deq = dequeue_req && !queue_empty;

  // Only one slot left in the head row
  assign head_last = !(vld_hi[head_row] && vld_lo[head_row]);

  always_ff @(posedge clk) begin
    if (do_enq) begin
      slot_hi[tail_row] <= wdata_in[1];
      slot_lo[tail_row] <= wdata_in[0];
    end
  end

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      vld_hi <= '0;
      vld_lo <= '0;
      head   <= '0;
      tail   <= '0;
    end else begin
      // High slot leaves first
      if (do_deq) begin
        if (vld_hi[head_row]) begin
          vld_hi[head_row] <= 1'b0;
        end else begin
          vld_lo[head_row] <= 1'b0;
        end
        if (head_last) begin
          head <= head + 1'b1;
        end
      end
      if (do_enq) begin
        vld_hi[tail_row] <= enqueue_req[1];
        vld_lo[tail_row] <= enqueue_req[0];
        tail             <= tail + 1'b1;
      end
    end
  end

  assign rdata_out   = vld_hi[head_row] ? slot_hi[head_row] : slot_lo[head_row];
  assign queue_full  = (head[PW] != tail[PW]) && (head_row == tail_row);
  assign queue_empty = (head[PW] == tail[PW]) && (head_row == tail_row);

  // Vertex count bounded by Q_SIZE keeps both of these unreachable
  a_no_enq_full: assert property (@(posedge clk) disable iff (bfs_rst)
    |enqueue_req |-> !queue_full)
    else $error("queue_main: enqueue while full");

  a_no_deq_empty: assert property (@(posedge clk) disable iff (bfs_rst)
    dequeue_req |-> !queue_empty)
    else $error("queue_main: dequeue while empty");

endmodule

`default_nettype wire

//--- design/frontier_dispatch.sv
//********************************************************************
// Dispatcher: moves queue head entries into free neighbor lanes
//********************************************************************

`default_nettype none

`include "bfs_settings.svh"

module frontier_dispatch (
  input  logic                                  clk,
  input  logic                                  bfs_rst,
  input  bfs_pkg::frontier_entry_t              rdata_out,
  input  logic                                  queue_empty,
  output logic                                  dequeue_req,
  output logic [`BFS_LANES-1:0]                 job_req,
  output bfs_pkg::lane_job_t [`BFS_LANES-1:0]   job,
  input  logic [`BFS_LANES-1:0]                 job_ack,
  output logic                                  idle
);

  localparam int LW = (`BFS_LANES > 1) ? $clog2(`BFS_LANES) : 1;

  logic [`BFS_LANES-1:0] lane_open;
  logic [LW-1:0]         sel;
  logic                  sel_vld;
  logic                  issue;

  // Handshake in progress on a job stream
  assign lane_open = job_req | job_ack;

  // Lowest lane with a closed handshake
  always_comb begin
    sel     = '0;
    sel_vld = 1'b0;
    for (int i = `BFS_LANES - 1; i >= 0; i--) begin
      if (!lane_open[i]) begin
        sel     = LW'(i);
        sel_vld = 1'b1;
      end
    end
  end

  // Head is stale while the previous dequeue is in flight
  assign issue = !queue_empty && !dequeue_req && sel_vld;

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      job_req     <= '0;
      dequeue_req <= 1'b0;
    end else begin
      dequeue_req <= issue;
      for (int i = 0; i < `BFS_LANES; i++) begin
        if (job_req[i] && job_ack[i]) begin
          job_req[i] <= 1'b0;
        end
      end
      if (issue) begin
        job_req[sel] <= 1'b1;
      end
    end
  end

  // Job word held until the lane has acked
  always_ff @(posedge clk) begin
    if (issue) begin
      job[sel].entry <= rdata_out;
    end
  end

  assign idle = !(|lane_open);

  a_one_issue: assert property (@(posedge clk) disable iff (bfs_rst)
    $onehot0(job_req & ~$past(job_req)))
    else $error("frontier_dispatch: more than one job_req rose");

endmodule

`default_nettype wire

//--- design/neighbor_lane.sv
//********************************************************************
// Neighbor lane: expands one vertex into its in-range children
//********************************************************************

`default_nettype none

`include "bfs_settings.svh"

module neighbor_lane (
  input  logic                     clk,
  input  logic                     bfs_rst,
  input  logic [`BFS_VERTEX_W-1:0] vertex_count,
  input  logic                     job_req,
  input  bfs_pkg::lane_job_t       job,
  output logic                     job_ack,
  output logic                     res_req,
  output bfs_pkg::lane_result_t    result,
  input  logic                     res_ack,
  output logic                     busy
);

  typedef enum logic [2:0] {
    L_IDLE,
    L_ACK,
    L_GAP,
    L_RES,
    L_REL
  } lane_state_t;

  lane_state_t state;

  // One extra bit so 2v+2 cannot wrap
  logic [`BFS_VERTEX_W:0]  kid_a;
  logic [`BFS_VERTEX_W:0]  kid_b;
  logic [`BFS_LEVEL_W-1:0] kid_level;
  bfs_pkg::lane_result_t   next_res;

  assign kid_a     = {job.entry.vertex, 1'b1};
  assign kid_b     = kid_a + 1'b1;
  assign kid_level = job.entry.level + 1'b1;

  always_comb begin
    next_res.valid[1]        = kid_a < {1'b0, vertex_count};
    next_res.valid[0]        = kid_b < {1'b0, vertex_count};
    next_res.child[1].level  = kid_level;
    next_res.child[1].vertex = kid_a[`BFS_VERTEX_W-1:0];
    next_res.child[0].level  = kid_level;
    next_res.child[0].vertex = kid_b[`BFS_VERTEX_W-1:0];
  end

  // Result is offered even with both children dropped
  always_ff @(posedge clk) begin
    if (state == L_IDLE && job_req) begin
      result <= next_res;
    end
  end

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      state <= L_IDLE;
    end else begin
      case (state)
        L_IDLE:  if (job_req) state <= L_ACK;
        L_ACK:   if (!job_req) state <= L_GAP;
        L_GAP:   state <= L_RES;
        L_RES:   if (res_ack) state <= L_REL;
        L_REL:   if (!res_ack) state <= L_IDLE;
        default: state <= L_IDLE;
      endcase
    end
  end

  assign job_ack = (state == L_ACK);
  assign res_req = (state == L_RES);
  assign busy    = (state != L_IDLE);

endmodule

`default_nettype wire

//--- design/frontier_collect.sv
//********************************************************************
// Collector: root seeding, round-robin lane drain, child enqueue
// and the visit output stream
//********************************************************************

`default_nettype none

`include "bfs_settings.svh"

module frontier_collect (
  input  logic                                   clk,
  input  logic                                   bfs_rst,
  input  logic                                   start_req,
  output logic                                   start_ack,
  input  logic [`BFS_VERTEX_W-1:0]               root,
  input  logic [`BFS_VERTEX_W-1:0]               vertex_count,
  input  logic [`BFS_LANES-1:0]                  res_req,
  input  bfs_pkg::lane_result_t [`BFS_LANES-1:0] result,
  output logic [`BFS_LANES-1:0]                  res_ack,
  input  logic                                   queue_full,
  output logic [1:0]                             enqueue_req,
  output bfs_pkg::frontier_entry_t [1:0]         wdata_in,
  output logic                                   visit_req,
  output bfs_pkg::visit_t                        visit,
  input  logic                                   visit_ack,
  output logic                                   idle,
  output logic                                   started
);

  localparam int LW = (`BFS_LANES > 1) ? $clog2(`BFS_LANES) : 1;
  localparam int CW = `BFS_VERTEX_W + 1;

  typedef enum logic [2:0] {
    C_IDLE,
    C_START,
    C_VISIT,
    C_VISIT_REL,
    C_RES_ACK
  } col_state_t;

  col_state_t               state;
  logic [LW-1:0]            grant;
  logic [LW-1:0]            pick;
  logic                     pick_vld;
  logic [1:0]               vis_mask;
  logic                     from_lane;
  // Vertices enqueued but not yet returned by a lane
  logic [CW-1:0]            pending;
  logic [CW-1:0]            kid_cnt;
  // Collector was already idle in the previous cycle
  logic                     idle_q;
  logic                     root_ok;
  logic                     take_start;
  logic                     take_res;
  bfs_pkg::lane_result_t    res_pick;
  bfs_pkg::frontier_entry_t root_entry;

  // Next requesting lane after the last one served
  always_comb begin : rr_pick
    int unsigned idx;
    pick     = grant;
    pick_vld = 1'b0;
    for (int k = `BFS_LANES; k >= 1; k--) begin
      idx = (int'(grant) + k) % `BFS_LANES;
      if (res_req[idx]) begin
        pick     = LW'(idx);
        pick_vld = 1'b1;
      end
    end
  end

  assign res_pick          = result[pick];
  assign kid_cnt           = CW'(res_pick.valid[1]) + CW'(res_pick.valid[0]);
  assign root_ok           = root < vertex_count;
  assign root_entry.level  = '0;
  assign root_entry.vertex = root;

  // A new start only once the previous search has drained and the
  // last released lane is back in idle
  assign take_start = (state == C_IDLE) && idle_q && start_req && (pending == '0);
  assign take_res   = (state == C_IDLE) && !take_start && pick_vld;

  always_ff @(posedge clk) begin
    if (take_start) begin
      wdata_in[1] <= root_entry;
      wdata_in[0] <= '0;
    end else if (take_res) begin
      wdata_in <= res_pick.child;
    end
    if (state == C_VISIT_REL && !visit_ack) begin
      visit.entry <= vis_mask[1] ? wdata_in[1] : wdata_in[0];
    end
  end

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      state       <= C_IDLE;
      start_ack   <= 1'b0;
      res_ack     <= '0;
      visit_req   <= 1'b0;
      enqueue_req <= 2'b00;
      vis_mask    <= 2'b00;
      from_lane   <= 1'b0;
      pending     <= '0;
      started     <= 1'b0;
      grant       <= '0;
      idle_q      <= 1'b0;
    end else begin
      enqueue_req <= 2'b00;
      idle_q      <= (state == C_IDLE);
      case (state)
        C_IDLE: begin
          if (take_start) begin
            // Out-of-range root gives an empty search
            start_ack   <= 1'b1;
            started     <= 1'b1;
            enqueue_req <= {root_ok, 1'b0};
            vis_mask    <= {root_ok, 1'b0};
            pending     <= CW'(root_ok);
            from_lane   <= 1'b0;
            state       <= C_START;
          end else if (take_res) begin
            grant       <= pick;
            enqueue_req <= res_pick.valid;
            vis_mask    <= res_pick.valid;
            pending     <= pending + kid_cnt - 1'b1;
            from_lane   <= 1'b1;
            state       <= C_VISIT_REL;
          end
        end
        C_START: begin
          if (!start_req) begin
            start_ack <= 1'b0;
            state     <= C_VISIT_REL;
          end
        end
        C_VISIT: begin
          if (visit_ack) begin
            visit_req <= 1'b0;
            state     <= C_VISIT_REL;
          end
        end
        C_VISIT_REL: begin
          if (!visit_ack) begin
            if (|vis_mask) begin
              // High child first, same order as the queue
              vis_mask  <= vis_mask[1] ? {1'b0, vis_mask[0]} : 2'b00;
              visit_req <= 1'b1;
              state     <= C_VISIT;
            end else if (from_lane) begin
              res_ack[grant] <= 1'b1;
              state          <= C_RES_ACK;
            end else begin
              state <= C_IDLE;
            end
          end
        end
        C_RES_ACK: begin
          if (!res_req[grant]) begin
            res_ack[grant] <= 1'b0;
            state          <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  assign idle = (state == C_IDLE);

  a_enq_not_full: assert property (@(posedge clk) disable iff (bfs_rst)
    |enqueue_req |-> !queue_full)
    else $error("frontier_collect: enqueue met a full queue");

  // Every lane result belongs to a vertex this collector enqueued
  a_pending_live: assert property (@(posedge clk) disable iff (bfs_rst)
    take_res |-> pending != '0)
    else $error("frontier_collect: lane result with nothing pending");

endmodule

`default_nettype wire

//--- design/bfs_frontier.sv
//********************************************************************
// BFS frontier engine top: queue, dispatcher, lanes, collector
//********************************************************************

`default_nettype none

`include "bfs_settings.svh"

module bfs_frontier (
  input  logic                     clk,
  input  logic                     bfs_rst,
  input  logic                     start_req,
  output logic                     start_ack,
  input  logic [`BFS_VERTEX_W-1:0] root,
  // Held for the whole search, the lanes read it live
  input  logic [`BFS_VERTEX_W-1:0] vertex_count,
  output logic                     visit_req,
  output bfs_pkg::visit_t          visit,
  input  logic                     visit_ack,
  output logic                     done
);

  logic [1:0]                             enqueue_req;
  bfs_pkg::frontier_entry_t [1:0]         wdata_in;
  logic                                   dequeue_req;
  bfs_pkg::frontier_entry_t               rdata_out;
  logic                                   queue_full;
  logic                                   queue_empty;
  logic [`BFS_LANES-1:0]                  job_req;
  logic [`BFS_LANES-1:0]                  job_ack;
  bfs_pkg::lane_job_t [`BFS_LANES-1:0]    job;
  logic [`BFS_LANES-1:0]                  res_req;
  logic [`BFS_LANES-1:0]                  res_ack;
  bfs_pkg::lane_result_t [`BFS_LANES-1:0] lane_res;
  logic [`BFS_LANES-1:0]                  lane_busy;
  logic                                   disp_idle;
  logic                                   col_idle;
  logic                                   started;

  queue_main #(
    .Q_SIZE(`BFS_Q_SIZE)
  ) queue_main_i (
    .clk        (clk),
    .bfs_rst    (bfs_rst),
    .enqueue_req(enqueue_req),
    .wdata_in   (wdata_in),
    .dequeue_req(dequeue_req),
    .rdata_out  (rdata_out),
    .queue_full (queue_full),
    .queue_empty(queue_empty)
  );

  frontier_dispatch frontier_dispatch_i (
    .clk        (clk),
    .bfs_rst    (bfs_rst),
    .rdata_out  (rdata_out),
    .queue_empty(queue_empty),
    .dequeue_req(dequeue_req),
    .job_req    (job_req),
    .job        (job),
    .job_ack    (job_ack),
    .idle       (disp_idle)
  );

  for (genvar i = 0; i < `BFS_LANES; i++) begin : g_lane
    neighbor_lane neighbor_lane_i (
      .clk         (clk),
      .bfs_rst     (bfs_rst),
      .vertex_count(vertex_count),
      .job_req     (job_req[i]),
      .job         (job[i]),
      .job_ack     (job_ack[i]),
      .res_req     (res_req[i]),
      .result      (lane_res[i]),
      .res_ack     (res_ack[i]),
      .busy        (lane_busy[i])
    );
  end

  frontier_collect frontier_collect_i (
    .clk         (clk),
    .bfs_rst     (bfs_rst),
    .start_req   (start_req),
    .start_ack   (start_ack),
    .root        (root),
    .vertex_count(vertex_count),
    .res_req     (res_req),
    .result      (lane_res),
    .res_ack     (res_ack),
    .queue_full  (queue_full),
    .enqueue_req (enqueue_req),
    .wdata_in    (wdata_in),
    .visit_req   (visit_req),
    .visit       (visit),
    .visit_ack   (visit_ack),
    .idle        (col_idle),
    .started     (started)
  );

  // Search over once nothing is left anywhere in the loop
  assign done = started && queue_empty && disp_idle && col_idle && !(|lane_busy);

endmodule

`default_nettype wire

//--- tb/bfs_frontier_tb.sv
//********************************************************************
// Testbench for the BFS frontier engine: start commands, visit
// acks with random delay, reference levels and result checks
//********************************************************************

`default_nettype none

`include "bfs_settings.svh"

module bfs_frontier_tb;

  localparam int CLK_HALF  = 5;
  localparam int DRIVE     = 1;
  localparam int ACK_WAIT  = 200;
  localparam int DONE_WAIT = 20000;
  localparam int R_IDLE    = 0;
  localparam int R_WAIT    = 1;
  localparam int R_HIGH    = 2;

  logic                     clk = 1'b0;
  logic                     bfs_rst;
  logic                     start_req;
  logic                     start_ack;
  logic [`BFS_VERTEX_W-1:0] root;
  logic [`BFS_VERTEX_W-1:0] vertex_count;
  logic                     visit_req;
  bfs_pkg::visit_t          visit;
  logic                     visit_ack = 1'b0;
  logic                     done;

  // Search under test, written by the main process only
  int     search_id;
  int     cur_root;
  int     cur_count;
  int     ack_max;
  int     main_errors;
  int     tests_run;
  int     tests_failed;
  bit     aborted;
  integer seed = 42;

  // Visit checker state
  int                       chk_id;
  int                       visit_cnt;
  int                       chk_errors;
  int                       resp_state;
  int                       ack_cnt;
  bit                       seen [`BFS_Q_SIZE];
  bfs_pkg::frontier_entry_t held;

  always #CLK_HALF clk = ~clk;

  bfs_frontier bfs_frontier_i (
    .clk         (clk),
    .bfs_rst     (bfs_rst),
    .start_req   (start_req),
    .start_ack   (start_ack),
    .root        (root),
    .vertex_count(vertex_count),
    .visit_req   (visit_req),
    .visit       (visit),
    .visit_ack   (visit_ack),
    .done        (done)
  );

  // Depth of v below r, or -1 when v is outside r's subtree below n
  function automatic int ref_level(input int r, input int n, input int v);
    int cur;
    int depth;
    cur   = v;
    depth = 0;
    if (v < 0 || v >= n) begin
      return -1;
    end
    while (cur > r) begin
      cur   = (cur - 1) / 2;
      depth = depth + 1;
    end
    if (cur == r) begin
      return depth;
    end
    return -1;
  endfunction

  function automatic int ref_count(input int r, input int n);
    int cnt;
    cnt = 0;
    for (int v = 0; v < n; v++) begin
      if (ref_level(r, n, v) >= 0) begin
        cnt = cnt + 1;
      end
    end
    return cnt;
  endfunction

  task automatic pick_delay(output int d);
    d = 0;
    if (ack_max > 0) begin
      d = int'($unsigned($random(seed)) % (ack_max + 1));
    end
  endtask

  task automatic record_visit(input bfs_pkg::frontier_entry_t ent);
    int v;
    int want;
    v = int'(ent.vertex);
    // First visit of a new search clears the seen set
    if (chk_id != search_id) begin
      for (int i = 0; i < `BFS_Q_SIZE; i++) begin
        seen[i] = 1'b0;
      end
      visit_cnt = 0;
      chk_id    = search_id;
    end
    visit_cnt = visit_cnt + 1;
    want      = ref_level(cur_root, cur_count, v);
    if (want < 0) begin
      $display("Error at time %0t: vertex %0d is not in the search from root %0d count %0d",
               $time, v, cur_root, cur_count);
      chk_errors++;
    end else if (seen[v]) begin
      $display("Error at time %0t: vertex %0d visited twice", $time, v);
      chk_errors++;
    end else begin
      seen[v] = 1'b1;
      if (int'(ent.level) != want) begin
        $display("Error at time %0t: vertex %0d at level %0d, expected %0d",
                 $time, v, ent.level, want);
        chk_errors++;
      end
    end
  endtask

  // Visit stream responder and checker, sampled at the rising edge
  always @(posedge clk) begin : visit_checker
    logic                     req_s;
    bfs_pkg::frontier_entry_t ent;
    req_s = visit_req;
    ent   = visit.entry;
    if (bfs_rst) begin
      resp_state = R_IDLE;
    end else begin
      if (resp_state == R_IDLE && req_s) begin
        record_visit(ent);
        held = ent;
        pick_delay(ack_cnt);
        resp_state = R_WAIT;
      end else if ((resp_state == R_WAIT || (resp_state == R_HIGH && req_s)) && ent != held) begin
        $display("Error at time %0t: visit data changed while visit_req was high", $time);
        chk_errors++;
      end
      if (resp_state == R_WAIT) begin
        if (ack_cnt == 0) begin
          resp_state = R_HIGH;
          #DRIVE visit_ack = 1'b1;
        end else begin
          ack_cnt = ack_cnt - 1;
        end
      end else if (resp_state == R_HIGH && !req_s) begin
        resp_state = R_IDLE;
        #DRIVE visit_ack = 1'b0;
      end
    end
  end

  task automatic wait_start_ack(input logic level, input int limit, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < limit; i++) begin
      @(posedge clk);
      if (start_ack == level) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      $display("Timeout: start_ack did not go to %0b within %0d cycles", level, limit);
      aborted = 1'b1;
    end
  endtask

  // Ack of a start raised while busy, done must be high the cycle before
  task automatic wait_ack_after_done(output bit ok);
    bit done_prev;
    ok        = 1'b0;
    done_prev = 1'b0;
    for (int i = 0; i < DONE_WAIT; i++) begin
      @(posedge clk);
      if (start_ack) begin
        ok = 1'b1;
        break;
      end
      done_prev = done;
    end
    if (!ok) begin
      $display("Timeout: start_ack did not go to 1 within %0d cycles", DONE_WAIT);
      aborted = 1'b1;
    end else if (!done_prev) begin
      $display("Error at time %0t: start_ack rose before done", $time);
      main_errors++;
    end
  endtask

  task automatic wait_done(output bit ok);
    ok = 1'b0;
    for (int i = 0; i < DONE_WAIT; i++) begin
      @(posedge clk);
      if (done) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      $display("Timeout: done did not rise within %0d cycles", DONE_WAIT);
      aborted = 1'b1;
    end
  endtask

  task automatic wait_visits(input int k, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < DONE_WAIT; i++) begin
      @(posedge clk);
      if (chk_id == search_id && visit_cnt >= k) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      $display("Timeout: fewer than %0d visits arrived within %0d cycles", k, DONE_WAIT);
      aborted = 1'b1;
    end
  endtask

  task automatic check_result();
    int want;
    int got;
    want = ref_count(cur_root, cur_count);
    got  = (chk_id == search_id) ? visit_cnt : 0;
    if (got != want) begin
      $display("Error at time %0t: %0d visits from root %0d, expected %0d",
               $time, got, cur_root, want);
      main_errors++;
    end
    for (int v = 0; v < cur_count; v++) begin
      if (ref_level(cur_root, cur_count, v) >= 0 && !(chk_id == search_id && seen[v])) begin
        $display("Error at time %0t: vertex %0d never visited", $time, v);
        main_errors++;
      end
    end
  endtask

  // Full start handshake, leaves the search running
  task automatic start_search(input int r, input int n, output bit ok);
    cur_root  = r;
    cur_count = n;
    search_id = search_id + 1;
    @(posedge clk);
    #DRIVE;
    root         = r[`BFS_VERTEX_W-1:0];
    vertex_count = n[`BFS_VERTEX_W-1:0];
    start_req    = 1'b1;
    wait_start_ack(1'b1, ACK_WAIT, ok);
    if (ok) begin
      #DRIVE start_req = 1'b0;
      wait_start_ack(1'b0, ACK_WAIT, ok);
    end
  endtask

  task automatic run_search(input int r, input int n);
    bit ok;
    start_search(r, n, ok);
    if (ok) begin
      wait_done(ok);
    end
    if (ok) begin
      check_result();
    end
  endtask

  // Second start raised mid-search on the same vertex count
  task automatic run_busy_start(input int r_b, input int r_c, input int n);
    bit ok;
    int got;
    start_search(r_b, n, ok);
    if (ok) begin
      wait_visits(3, ok);
    end
    if (ok) begin
      @(posedge clk);
      #DRIVE;
      root      = r_c[`BFS_VERTEX_W-1:0];
      start_req = 1'b1;
      wait_ack_after_done(ok);
    end
    if (ok) begin
      got = (chk_id == search_id) ? visit_cnt : 0;
      if (got != ref_count(r_b, n)) begin
        $display("Error at time %0t: busy start taken after %0d of %0d visits",
                 $time, got, ref_count(r_b, n));
        main_errors++;
      end
      check_result();
      cur_root  = r_c;
      search_id = search_id + 1;
      #DRIVE start_req = 1'b0;
      wait_start_ack(1'b0, ACK_WAIT, ok);
    end
    if (ok) begin
      wait_done(ok);
    end
    if (ok) begin
      check_result();
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs_now;
    errs_now  = main_errors + chk_errors;
    tests_run = tests_run + 1;
    if (errs_now == errs_before && !aborted) begin
      $display("%s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("%s: FAIL with %0d errors", name, errs_now - errs_before);
    end
  endtask

  initial begin : main
    int errs;
    bfs_rst      = 1'b1;
    start_req    = 1'b0;
    root         = '0;
    vertex_count = '0;
    repeat (16) @(posedge clk);
    #DRIVE bfs_rst = 1'b0;

    errs = main_errors + chk_errors;
    run_search(0, 64);
    finish_test("test 1 full search from root 0", errs);

    if (!aborted) begin
      errs = main_errors + chk_errors;
      run_search(5, 50);
      finish_test("test 2 subtree search from root 5", errs);
    end

    if (!aborted) begin
      errs = main_errors + chk_errors;
      run_search(40, 64);
      finish_test("test 3 leaf root 40", errs);
    end

    if (!aborted) begin
      errs    = main_errors + chk_errors;
      ack_max = 20;
      run_search(0, 64);
      ack_max = 0;
      finish_test("test 4 random visit_ack delays", errs);
    end

    if (!aborted) begin
      errs = main_errors + chk_errors;
      run_search(0, 30);
      if (!aborted) begin
        run_busy_start(2, 1, 60);
      end
      finish_test("test 5 back-to-back and busy start", errs);
    end

    $display("Summary: %0d tests run, %0d failed, %0d errors, timeout %0b",
             tests_run, tests_failed, main_errors + chk_errors, aborted);
    if (tests_failed == 0 && !aborted && main_errors + chk_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/bfs_pkg.sv
design/queue_main.sv
design/frontier_dispatch.sv
design/neighbor_lane.sv
design/frontier_collect.sv
design/bfs_frontier.sv
tb/bfs_frontier_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := bfs_frontier_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

SOURCES := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
